//--- sources.f
+incdir+logic
logic/bus_pkg.sv
logic/keypad_pkg.sv
logic/keypad_scanner.sv
logic/key_fifo.sv
logic/key_logger.sv
logic/wb_write_manager.sv
logic/keypad_logger_top.sv
test/keypad_logger_tb.sv

//--- Bender.yml
package:
  name: keypad_logger

sources:
  - include_dirs:
      - logic
    files:
      - logic/bus_pkg.sv
      - logic/keypad_pkg.sv
      - logic/keypad_scanner.sv
      - logic/key_fifo.sv
      - logic/key_logger.sv
      - logic/wb_write_manager.sv
      - logic/keypad_logger_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/keypad_logger_tb.sv

//--- test/keypad_logger_tb.sv
// ------------------------------
// Testbench for keypad_logger_top
// Keypad model holds one key at a time
// Slave acks after 0..3 cycles unless stalled
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "keypad_consts.svh"

module keypad_logger_tb;
   import keypad_pkg::*;
   import bus_pkg::*;

   localparam int SCAN_CYCLES = 4 * `KP_SCAN_DIV;
   localparam int N_ROWS      = 20;
   localparam int DRAIN_LIMIT = 500;

   // One row of stimulus and expectation
   typedef struct packed {
      logic       pressed;
      key_code_t  key;
      logic [7:0] scans;
      logic       en;
      logic       stall;
      logic       log_exp;
   } stim_t;

   logic       clk;
   logic       rst_i;
   logic       en_i;
   logic [3:0] rows_i = 4'b0000;
   logic       ack_i  = 1'b0;
   logic [3:0] cols_o;
   logic       cyc_o;
   logic       stb_o;
   wb_req_t    wb_req_o;
   logic       overflow_o;

   // Keypad and slave state
   logic        key_on;
   key_code_t   key_now;
   logic        stall;
   logic        in_cycle;
   int          ack_wait;
   wb_req_t     held_req;
   logic [31:0] rng_state = 32'd36;

   // Reference model
   logic [7:0] model_seq;
   int         stall_held;
   logic       model_overflow;
   wb_req_t    exp_q[$];
   wb_req_t    obs_q[$];
   stim_t      stim [N_ROWS];

   keypad_logger_top u_dut (
      .clk        (clk),
      .rst_i      (rst_i),
      .en_i       (en_i),
      .rows_i     (rows_i),
      .ack_i      (ack_i),
      .cols_o     (cols_o),
      .cyc_o      (cyc_o),
      .stb_o      (stb_o),
      .wb_req_o   (wb_req_o),
      .overflow_o (overflow_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic end_in_failure();
      $display("Testbench failed");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic fail_value(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      end_in_failure();
   endtask

   task automatic fail_plain(input string msg);
      $display("%s", msg);
      end_in_failure();
   endtask

   task automatic check_req(input wb_req_t got, input wb_req_t want, input string what);
      if (got !== want) begin
         fail_value($sformatf(
            "%s, got adr %h dat %h sel %h we %b, want adr %h dat %h sel %h we %b",
            what, got.adr, got.dat, got.sel, got.we,
            want.adr, want.dat, want.sel, want.we));
      end
   endtask

   task automatic check_code(input key_code_t got, input key_code_t want);
      if (got !== want) begin
         fail_value($sformatf("logged key code %0d, want %0d", got, want));
      end
   endtask

   task automatic check_overflow(input logic got, input logic want);
      if (got !== want) begin
         fail_value($sformatf("overflow_o is %b, want %b", got, want));
      end
   endtask

   // 32-bit xorshift
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // Pressed key shows on its row while its column is driven
   always @(negedge clk) begin : keypad_model
      logic [3:0] r;
      r = 4'b0000;
      if (key_on && cols_o[key_now[1:0]]) begin
         r[key_now[3:2]] = 1'b1;
      end
      rows_i = r;
   end

   // Wishbone slave that records each acked write
   always @(negedge clk) begin : wb_slave
      if (rst_i) begin
         ack_i    = 1'b0;
         in_cycle = 1'b0;
      end else if (stb_o !== cyc_o) begin
         fail_value($sformatf("stb_o is %b while cyc_o is %b", stb_o, cyc_o));
      end else if (ack_i) begin
         // Cycle closed at the last rising edge
         ack_i    = 1'b0;
         in_cycle = 1'b0;
      end else if (cyc_o && stb_o) begin
         if (!in_cycle) begin
            in_cycle = 1'b1;
            held_req = wb_req_o;
            ack_wait = int'(next_rand() % 4);
         end else begin
            check_req(wb_req_o, held_req, "request moved during bus cycle");
         end
         if (ack_wait > 0) begin
            ack_wait = ack_wait - 1;
         end else if (!stall) begin
            ack_i = 1'b1;
            obs_q.push_back(wb_req_o);
         end
      end else if (in_cycle) begin
         fail_value("cyc_o dropped before ack");
      end
   end

   // Expected record for one accepted key
   task automatic model_accept(input key_code_t key);
      wb_req_t r;
      if (stall && (stall_held >= 1 + `KP_FIFO_DEPTH)) begin
         // One write in flight and a full FIFO
         model_overflow = 1'b1;
      end else begin
         r.adr = `KP_LOG_BASE + 32'(4 * (int'(model_seq) % `KP_LOG_WORDS));
         r.dat = (32'(model_seq) << 8) | 32'(key);
         r.sel = 4'hF;
         r.we  = 1'b1;
         exp_q.push_back(r);
         model_seq = model_seq + 8'd1;
         if (stall) begin
            stall_held = stall_held + 1;
         end
      end
   endtask

   task automatic run_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         if (!en_i && (cols_o !== 4'b0000)) begin
            fail_value($sformatf("cols_o is %b while en_i is low", cols_o));
         end
      end
   endtask

   task automatic drain_writes();
      int      waited;
      wb_req_t got;
      wb_req_t want;
      waited = 0;
      while (obs_q.size() < exp_q.size()) begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > DRAIN_LIMIT) begin
            fail_plain("Timeout: an expected log write never reached the bus");
         end
      end
      while (exp_q.size() > 0) begin
         got  = obs_q.pop_front();
         want = exp_q.pop_front();
         check_code(key_code_t'(got.dat[3:0]), key_code_t'(want.dat[3:0]));
         check_req(got, want, "log write");
      end
      if (obs_q.size() != 0) begin
         fail_value("log write without an accepted key");
      end
   endtask

   task automatic expect_idle_bus(input int scans);
      for (int i = 0; i < scans * SCAN_CYCLES; i++) begin
         @(negedge clk);
         if (cyc_o !== 1'b0) begin
            fail_value("bus cycle started without an accepted key");
         end
      end
   endtask

   task automatic apply_row(input stim_t s);
      en_i    = s.en;
      stall   = s.stall;
      key_now = s.key;
      key_on  = s.pressed;
      if (!s.stall) begin
         stall_held = 0;
      end
      if (s.pressed && s.log_exp) begin
         model_accept(s.key);
      end
      run_cycles(int'(s.scans) * SCAN_CYCLES);
      key_on = 1'b0;
      // Empty scans re-arm the scanner
      run_cycles(2 * SCAN_CYCLES);
      if (!s.stall) begin
         drain_writes();
      end
      check_overflow(overflow_o, model_overflow);
      if (!s.log_exp) begin
         expect_idle_bus(10);
      end
   endtask

   task automatic load_stimulus();
      // pressed, key, scans, en, stall, log expected
      stim[0]  = '{1'b1, 4'd5,  8'd5, 1'b1, 1'b0, 1'b1};
      // Too short to debounce
      stim[1]  = '{1'b1, 4'd10, 8'd2, 1'b1, 1'b0, 1'b0};
      stim[2]  = '{1'b1, 4'd0,  8'd5, 1'b1, 1'b0, 1'b1};
      stim[3]  = '{1'b1, 4'd15, 8'd5, 1'b1, 1'b0, 1'b1};
      // Scanner disabled
      stim[4]  = '{1'b1, 4'd3,  8'd5, 1'b0, 1'b0, 1'b0};
      stim[5]  = '{1'b1, 4'd7,  8'd5, 1'b1, 1'b0, 1'b1};
      stim[6]  = '{1'b1, 4'd12, 8'd5, 1'b1, 1'b0, 1'b1};
      stim[7]  = '{1'b1, 4'd9,  8'd5, 1'b1, 1'b0, 1'b1};
      stim[8]  = '{1'b1, 4'd6,  8'd5, 1'b1, 1'b0, 1'b1};
      stim[9]  = '{1'b1, 4'd1,  8'd5, 1'b1, 1'b0, 1'b1};
      // Ninth record wraps to the first word
      stim[10] = '{1'b1, 4'd14, 8'd5, 1'b1, 1'b0, 1'b1};
      stim[11] = '{1'b1, 4'd2,  8'd1, 1'b1, 1'b0, 1'b0};
      // Ack withheld so the sixth press is lost
      stim[12] = '{1'b1, 4'd4,  8'd5, 1'b1, 1'b1, 1'b1};
      stim[13] = '{1'b1, 4'd8,  8'd5, 1'b1, 1'b1, 1'b1};
      stim[14] = '{1'b1, 4'd11, 8'd5, 1'b1, 1'b1, 1'b1};
      stim[15] = '{1'b1, 4'd13, 8'd5, 1'b1, 1'b1, 1'b1};
      stim[16] = '{1'b1, 4'd2,  8'd5, 1'b1, 1'b1, 1'b1};
      stim[17] = '{1'b1, 4'd6,  8'd5, 1'b1, 1'b1, 1'b1};
      // Ack released and buffered keys drain
      stim[18] = '{1'b0, 4'd0,  8'd2, 1'b1, 1'b0, 1'b0};
      stim[19] = '{1'b1, 4'd10, 8'd5, 1'b1, 1'b0, 1'b1};
   endtask

   initial begin
      rst_i          = 1'b1;
      en_i           = 1'b1;
      key_on         = 1'b0;
      key_now        = '0;
      stall          = 1'b0;
      model_seq      = 8'd0;
      stall_held     = 0;
      model_overflow = 1'b0;
      load_stimulus();
      repeat (8) @(negedge clk);
      // Outputs quiet at the end of reset
      if ((cyc_o !== 1'b0) || (stb_o !== 1'b0) || (cols_o !== 4'b0000) ||
          (wb_req_o.we !== 1'b0)) begin
         fail_value("bus or column outputs not low in reset");
      end
      check_overflow(overflow_o, 1'b0);
      rst_i = 1'b0;
      for (int i = 0; i < N_ROWS; i++) begin
         apply_row(stim[i]);
      end
      $display("Testbench passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/keypad_logger_top.sv
// ------------------------------
// Keypad logger top level
// Wishbone writes only, read data not used
// Keys still drain to the bus while en_i is low
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module keypad_logger_top (
   input  logic             clk,
   input  logic             rst_i,
   input  logic             en_i,
   input  logic [3:0]       rows_i,
   input  logic             ack_i,
   output logic [3:0]       cols_o,
   output logic             cyc_o,
   output logic             stb_o,
   output bus_pkg::wb_req_t wb_req_o,
   output logic             overflow_o
);
   import keypad_pkg::*;
   import bus_pkg::*;

   // Scanner to FIFO
   logic       key_valid;
   key_event_t key_event;

   // FIFO to logger
   key_event_t head_event;
   logic       not_empty;
   logic       pop;

   // Logger to bus master
   logic      wr;
   wb_write_t cmd;
   logic      busy;

   keypad_scanner u_scanner (
      .clk         (clk),
      .rst_i       (rst_i),
      .en_i        (en_i),
      .rows_i      (rows_i),
      .cols_o      (cols_o),
      .key_valid_o (key_valid),
      .key_o       (key_event)
   );

   key_fifo u_fifo (
      .clk         (clk),
      .rst_i       (rst_i),
      .push_i      (key_valid),
      .data_i      (key_event),
      .pop_i       (pop),
      .data_o      (head_event),
      .not_empty_o (not_empty),
      .overflow_o  (overflow_o)
   );

   key_logger u_logger (
      .clk         (clk),
      .rst_i       (rst_i),
      .not_empty_i (not_empty),
      .event_i     (head_event),
      .busy_i      (busy),
      .pop_o       (pop),
      .wr_o        (wr),
      .cmd_o       (cmd)
   );

   wb_write_manager u_wb_mgr (
      .clk      (clk),
      .rst_i    (rst_i),
      .wr_i     (wr),
      .cmd_i    (cmd),
      .ack_i    (ack_i),
      .busy_o   (busy),
      .cyc_o    (cyc_o),
      .stb_o    (stb_o),
      .wb_req_o (wb_req_o)
   );

endmodule

`default_nettype wire

//--- logic/wb_write_manager.sv
// ------------------------------
// Single-beat Wishbone write master
// No reads, no retry or error handling
// Strobes while busy are ignored
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module wb_write_manager (
   input  logic               clk,
   input  logic               rst_i,
   input  logic               wr_i,
   input  bus_pkg::wb_write_t cmd_i,
   input  logic               ack_i,
   output logic               busy_o,
   output logic               cyc_o,
   output logic               stb_o,
   output bus_pkg::wb_req_t   wb_req_o
);
   import bus_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_ACTIVE
   } state_t;

   state_t    state;
   wb_write_t req_q;
   logic      active;

   // Bus cycle open from the cycle after the strobe until ack
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (wr_i) begin
                  state <= ST_ACTIVE;
               end
            end
            ST_ACTIVE: begin
               if (ack_i) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Held stable for the whole cycle
   always_ff @(posedge clk) begin
      if ((state == ST_IDLE) && wr_i) begin
         req_q <= cmd_i;
      end
   end

   always_comb begin
      active = (state == ST_ACTIVE);
      busy_o = active;
      cyc_o  = active;
      stb_o  = active;
      wb_req_o.adr = req_q.adr;
      wb_req_o.dat = req_q.dat;
      // Full word writes
      wb_req_o.sel = {4{active}};
      wb_req_o.we  = active;
   end

endmodule

`default_nettype wire

//--- logic/key_logger.sv
// ------------------------------
// Key event to log record writer
// One command in flight at a time
// Sequence number wraps at 256
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "keypad_consts.svh"

module key_logger (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   not_empty_i,
   input  keypad_pkg::key_event_t event_i,
   input  logic                   busy_i,
   output logic                   pop_o,
   output logic                   wr_o,
   output bus_pkg::wb_write_t     cmd_o
);
   import keypad_pkg::*;

   localparam int SLOT_W = $clog2(`KP_LOG_WORDS);

   // Strobe issued last cycle, busy not yet up
   logic              wr_q;
   logic [7:0]        seq;
   logic [SLOT_W-1:0] slot;
   key_code_t         code;

   always_comb begin
      wr_o  = not_empty_i && !busy_i && !wr_q;
      // Pop together with the write strobe
      pop_o = wr_o;
      code  = {event_i.row, event_i.col};
      // Word slot in the circular window
      cmd_o.adr = `KP_LOG_BASE + (32'(slot) << 2);
      // Record layout, sequence in 15:8 and key in 3:0
      cmd_o.dat = {16'h0000, seq, 4'h0, code};
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_q <= 1'b0;
         seq  <= 8'd0;
         slot <= '0;
      end else begin
         wr_q <= wr_o;
         if (wr_o) begin
            seq <= seq + 8'd1;
            if (slot == SLOT_W'(`KP_LOG_WORDS - 1)) begin
               slot <= '0;
            end else begin
               slot <= slot + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/key_fifo.sv
// ------------------------------
// Key event FIFO
// Push while full is lost, overflow sticks until reset
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "keypad_consts.svh"

module key_fifo (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   push_i,
   input  keypad_pkg::key_event_t data_i,
   input  logic                   pop_i,
   output keypad_pkg::key_event_t data_o,
   output logic                   not_empty_o,
   output logic                   overflow_o
);
   import keypad_pkg::*;

   localparam int PTR_W = $clog2(`KP_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`KP_FIFO_DEPTH + 1);

   key_event_t       mem [`KP_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_push;
   logic             do_pop;

   // Wrap at depth
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(`KP_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_comb begin
      full        = (count == CNT_W'(`KP_FIFO_DEPTH));
      not_empty_o = (count != '0);
      do_push     = push_i && !full;
      do_pop      = pop_i && not_empty_o;
      // Head shown straight from storage
      data_o      = mem[rd_ptr];
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Dropped key
         if (push_i && full) begin
            overflow_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

endmodule

`default_nettype wire

//--- logic/keypad_scanner.sv
// ------------------------------
// 4x4 matrix scanner, one-hot active-high columns
// Rows must read high for a pressed key
// Lowest key number wins on multiple presses
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "keypad_consts.svh"

module keypad_scanner (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   en_i,
   input  logic [3:0]             rows_i,
   output logic [3:0]             cols_o,
   output logic                   key_valid_o,
   output keypad_pkg::key_event_t key_o
);
   import keypad_pkg::*;

   localparam int DIV_W = $clog2(`KP_SCAN_DIV);
   localparam int DEB_W = $clog2(`KP_DEBOUNCE_SCANS + 1);

   // Column timing
   logic [DIV_W-1:0] div_cnt;
   key_idx_t         col_idx;
   logic             div_last;
   logic             sample;
   logic             scan_last;

   // Best key within current scan
   logic       found;
   key_event_t best;
   key_event_t cand;
   logic       samp_hit;
   logic       better;
   logic       scan_hit;
   key_event_t scan_key;

   // Debounce across scans
   key_event_t       prev_key;
   logic [DEB_W-1:0] stable_cnt;
   logic [DEB_W-1:0] stable_nxt;
   logic             armed;

   // Lowest pressed row in the driven column
   always_comb begin
      cand.col = col_idx;
      cand.row = 2'd0;
      for (int r = 3; r >= 0; r--) begin
         if (rows_i[r]) begin
            cand.row = key_idx_t'(r);
         end
      end
   end

   always_comb begin
      div_last  = (div_cnt == DIV_W'(`KP_SCAN_DIV - 1));
      // Sample only in last cycle of a driven column
      sample    = div_last && (cols_o != 4'b0000);
      scan_last = sample && (col_idx == 2'd3);
      samp_hit  = sample && (rows_i != 4'b0000);
      better    = samp_hit && (!found || (cand < best));
      scan_hit  = found || samp_hit;
      scan_key  = better ? cand : best;
      // Saturating count of matching scans
      if (!scan_hit) begin
         stable_nxt = '0;
      end else if ((stable_cnt != '0) && (scan_key == prev_key)) begin
         if (stable_cnt == DEB_W'(`KP_DEBOUNCE_SCANS)) begin
            stable_nxt = stable_cnt;
         end else begin
            stable_nxt = stable_cnt + 1'b1;
         end
      end else begin
         stable_nxt = DEB_W'(1);
      end
   end

   // Column drive, idle while disabled
   always_ff @(posedge clk) begin
      if (rst_i || !en_i) begin
         div_cnt <= '0;
         col_idx <= '0;
         cols_o  <= 4'b0000;
      end else if (cols_o == 4'b0000) begin
         cols_o <= 4'b0001;
      end else if (div_last) begin
         div_cnt <= '0;
         col_idx <= col_idx + 1'b1;
         cols_o  <= {cols_o[2:0], cols_o[3]};
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // Scan result and debounce control
   always_ff @(posedge clk) begin
      if (rst_i || !en_i) begin
         found       <= 1'b0;
         stable_cnt  <= '0;
         armed       <= 1'b1;
         key_valid_o <= 1'b0;
      end else begin
         key_valid_o <= 1'b0;
         if (scan_last) begin
            found      <= 1'b0;
            stable_cnt <= stable_nxt;
            // An empty scan re-arms
            if (!scan_hit) begin
               armed <= 1'b1;
            end else if (armed && (stable_nxt == DEB_W'(`KP_DEBOUNCE_SCANS))) begin
               key_valid_o <= 1'b1;
               armed       <= 1'b0;
            end
         end else if (samp_hit) begin
            found <= 1'b1;
         end
      end
   end

   // Key payload
   always_ff @(posedge clk) begin
      if (better) begin
         best <= cand;
      end
      if (scan_last) begin
         prev_key <= scan_key;
         key_o    <= scan_key;
      end
   end

endmodule

`default_nettype wire

//--- logic/keypad_pkg.sv
// ------------------------------
// Key matrix types, 4x4 only
// Key number is row*4 + col
// ------------------------------

`default_nettype none

package keypad_pkg;

   // Row or column index in the matrix
   typedef logic [1:0] key_idx_t;

   // Accepted key, row in the upper bits
   typedef struct packed {
      key_idx_t row;
      key_idx_t col;
   } key_event_t;

   // Flat key number
   // Same bit order as key_event_t
   typedef logic [3:0] key_code_t;

endpackage

`default_nettype wire

//--- logic/bus_pkg.sv
// ------------------------------
// Wishbone types for the log path
// 32-bit classic bus, writes only
// ------------------------------

`default_nettype none

package bus_pkg;

   // Field widths of the management bus
   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   // Write command from logger to bus master
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
   } wb_write_t;

   // Request side of the bus master
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      // Byte lanes
      wb_sel_t sel;
      // High for a write
      logic    we;
   } wb_req_t;

endpackage

`default_nettype wire

//--- logic/keypad_consts.svh
// ------------------------------
// Keypad logger constants
// FIFO depth and log words need no power of two
// Log base must be word aligned
// ------------------------------

`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// Clock cycles each column stays driven
`define KP_SCAN_DIV 4

// Matching full scans before a key is accepted
`define KP_DEBOUNCE_SCANS 3

// Key events held between scanner and logger
`define KP_FIFO_DEPTH 4

// Byte address of first log word
`define KP_LOG_BASE 32'h3000_0000

// Words in the circular log window
`define KP_LOG_WORDS 8

`endif
